/* logic/alu_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared widths and types for the ALU stream pipeline
// Opcode numbering is fixed and used by the trace file
// Struct widths set the register slice widths at the top level
////////////////////////////////////////////////////////////////////////////

package alu_pkg;

    // Operand and result width
    localparam int XLEN = 32;
    // Command tag width
    localparam int TAG_W = 4;

    // Opcode encoding as numbered in the trace files
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_SLT = 3'd7
    } alu_op_e;

    // Execute unit select
    typedef enum logic [1:0] {
        UNIT_ADDER   = 2'd0,
        UNIT_LOGIC   = 2'd1,
        UNIT_SHIFT   = 2'd2,
        UNIT_COMPARE = 2'd3
    } alu_unit_e;

    // Logic unit function
    typedef enum logic [1:0] {
        LOGIC_AND = 2'd0,
        LOGIC_OR  = 2'd1,
        LOGIC_XOR = 2'd2
    } logic_sel_e;

    // Command as it enters the pipeline (71 bits)
    typedef struct packed {
        alu_op_e           op;
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
        logic [TAG_W-1:0]  tag;
    } alu_cmd_t;

    // Decoded controls with b already inverted for sub and slt (79 bits)
    typedef struct packed {
        alu_unit_e         unit;
        logic_sel_e        logic_sel;
        logic              invert_b;
        logic              shift_right;
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
        logic [4:0]        shamt;
        logic [TAG_W-1:0]  tag;
    } alu_ctl_t;

    // Result with zero flag (37 bits)
    typedef struct packed {
        logic [XLEN-1:0]   value;
        logic              zero;
        logic [TAG_W-1:0]  tag;
    } alu_res_t;

endpackage

/* logic/register_slice.sv */
////////////////////////////////////////////////////////////////////////////
// One-entry skid buffer on a valid/ready link, output fully registered
// One cycle latency, full throughput while out_ready stays high
// in_ready comes from a flop and never from out_ready
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module register_slice #(
    parameter int DW = 8
) (
    input  logic          clk,
    input  logic          rst_n,

    // Upstream side
    input  logic          in_valid,
    input  logic [DW-1:0] in_data,
    output logic          in_ready,

    // Downstream side
    output logic          out_valid,
    output logic [DW-1:0] out_data,
    input  logic          out_ready
);

    // Skid register holds the item that arrived while the output stalled
    logic          skid_valid;
    logic [DW-1:0] skid_data;

    logic in_fire;
    logic out_stall;

    // Input accepted only while the skid register is empty
    assign in_ready  = !skid_valid;
    assign in_fire   = in_valid && in_ready;
    // Output holds its item until the consumer takes it
    assign out_stall = out_valid && !out_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Control and output register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            skid_valid <= 1'b0;
            out_valid  <= 1'b0;
            out_data   <= '0;
        end else begin
            // Accepted input meets a stalled output, park it
            if (in_fire && out_stall) begin
                skid_valid <= 1'b1;
            end else if (out_ready) begin
                // Skid contents move to the output below
                skid_valid <= 1'b0;
            end

            // Output empty or being taken, so refill it
            if (!out_stall) begin
                out_valid <= in_valid || skid_valid;
                // Older item in the skid register goes first
                if (skid_valid) begin
                    out_data <= skid_data;
                end else if (in_valid) begin
                    out_data <= in_data;
                end
            end
        end
    end

    // Skid data tracks the input while empty and freezes once filled
    always_ff @(posedge clk) begin
        if (!skid_valid) begin
            skid_data <= in_data;
        end
    end

endmodule

/* logic/alu_decode.sv */
////////////////////////////////////////////////////////////////////////////
// Decode stage, purely combinational
// Handshake passes straight through, only the payload changes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_decode (
    input  logic              in_valid,
    input  alu_pkg::alu_cmd_t in_cmd,
    output logic              in_ready,

    output logic              out_valid,
    output alu_pkg::alu_ctl_t out_ctl,
    input  logic              out_ready
);

    assign out_valid = in_valid;
    assign in_ready  = out_ready;

    always_comb begin
        // Defaults for fields only some opcodes touch
        out_ctl.logic_sel   = alu_pkg::LOGIC_AND;
        out_ctl.invert_b    = 1'b0;
        out_ctl.shift_right = 1'b0;

        case (in_cmd.op)
            alu_pkg::OP_ADD: begin
                out_ctl.unit = alu_pkg::UNIT_ADDER;
            end
            alu_pkg::OP_SUB: begin
                // a + ~b + 1
                out_ctl.unit     = alu_pkg::UNIT_ADDER;
                out_ctl.invert_b = 1'b1;
            end
            alu_pkg::OP_AND: begin
                out_ctl.unit      = alu_pkg::UNIT_LOGIC;
                out_ctl.logic_sel = alu_pkg::LOGIC_AND;
            end
            alu_pkg::OP_OR: begin
                out_ctl.unit      = alu_pkg::UNIT_LOGIC;
                out_ctl.logic_sel = alu_pkg::LOGIC_OR;
            end
            alu_pkg::OP_XOR: begin
                out_ctl.unit      = alu_pkg::UNIT_LOGIC;
                out_ctl.logic_sel = alu_pkg::LOGIC_XOR;
            end
            alu_pkg::OP_SLL: begin
                out_ctl.unit = alu_pkg::UNIT_SHIFT;
            end
            alu_pkg::OP_SRL: begin
                out_ctl.unit        = alu_pkg::UNIT_SHIFT;
                out_ctl.shift_right = 1'b1;
            end
            alu_pkg::OP_SLT: begin
                // Compare runs a subtract in the shared adder
                out_ctl.unit     = alu_pkg::UNIT_COMPARE;
                out_ctl.invert_b = 1'b1;
            end
            default: begin
                out_ctl.unit = alu_pkg::UNIT_ADDER;
            end
        endcase

        out_ctl.a     = in_cmd.a;
        out_ctl.b     = out_ctl.invert_b ? ~in_cmd.b : in_cmd.b;
        // Only the low five bits of b count as shift amount
        out_ctl.shamt = in_cmd.b[4:0];
        out_ctl.tag   = in_cmd.tag;
    end

endmodule

/* logic/alu_execute.sv */
////////////////////////////////////////////////////////////////////////////
// Execute stage, purely combinational
// Expects b pre-inverted by decode for sub and slt
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_execute (
    input  logic              in_valid,
    input  alu_pkg::alu_ctl_t in_ctl,
    output logic              in_ready,

    output logic              out_valid,
    output alu_pkg::alu_res_t out_res,
    input  logic              out_ready
);

    logic [alu_pkg::XLEN-1:0] sum;
    logic                     overflow;
    logic                     less;
    logic [alu_pkg::XLEN-1:0] logic_res;
    logic [alu_pkg::XLEN-1:0] shift_src;
    logic [alu_pkg::XLEN-1:0] shift_out;
    logic [alu_pkg::XLEN-1:0] shift_res;
    logic [alu_pkg::XLEN-1:0] value;

    // Bit order flip so one right shifter also serves left shifts
    function automatic logic [alu_pkg::XLEN-1:0] bit_reverse(
        input logic [alu_pkg::XLEN-1:0] x
    );
        logic [alu_pkg::XLEN-1:0] r;
        for (int i = 0; i < alu_pkg::XLEN; i++) begin
            r[i] = x[alu_pkg::XLEN-1-i];
        end
        return r;
    endfunction

    assign out_valid = in_valid;
    assign in_ready  = out_ready;

    // Shared adder, invert_b doubles as carry-in
    assign sum = in_ctl.a + in_ctl.b + {{(alu_pkg::XLEN-1){1'b0}}, in_ctl.invert_b};

    // Signed overflow when operand signs agree and the sum sign differs
    assign overflow = (in_ctl.a[alu_pkg::XLEN-1] == in_ctl.b[alu_pkg::XLEN-1]) &&
                      (sum[alu_pkg::XLEN-1] != in_ctl.a[alu_pkg::XLEN-1]);
    assign less     = sum[alu_pkg::XLEN-1] ^ overflow;

    always_comb begin
        case (in_ctl.logic_sel)
            alu_pkg::LOGIC_AND: logic_res = in_ctl.a & in_ctl.b;
            alu_pkg::LOGIC_OR:  logic_res = in_ctl.a | in_ctl.b;
            alu_pkg::LOGIC_XOR: logic_res = in_ctl.a ^ in_ctl.b;
            default:            logic_res = '0;
        endcase
    end

    // Barrel shifter, logical right shift only
    always_comb begin
        shift_src = in_ctl.shift_right ? in_ctl.a : bit_reverse(in_ctl.a);
        shift_out = shift_src >> in_ctl.shamt;
        shift_res = in_ctl.shift_right ? shift_out : bit_reverse(shift_out);
    end

    // Result select by unit
    always_comb begin
        case (in_ctl.unit)
            alu_pkg::UNIT_ADDER:   value = sum;
            alu_pkg::UNIT_LOGIC:   value = logic_res;
            alu_pkg::UNIT_SHIFT:   value = shift_res;
            alu_pkg::UNIT_COMPARE: value = {{(alu_pkg::XLEN-1){1'b0}}, less};
            default:               value = '0;
        endcase
    end

    assign out_res.value = value;
    assign out_res.zero  = (value == '0);
    assign out_res.tag   = in_ctl.tag;

endmodule

/* logic/alu_stream_top.sv */
////////////////////////////////////////////////////////////////////////////
// ALU stream pipeline, three register slices around decode and execute
// Three cycle latency, one result per cycle, results leave in order
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_stream_top (
    input  logic                      clk,
    input  logic                      rst_n,

    // Command stream
    input  logic                      in_valid,
    input  alu_pkg::alu_op_e          in_op,
    input  logic [alu_pkg::XLEN-1:0]  in_a,
    input  logic [alu_pkg::XLEN-1:0]  in_b,
    input  logic [alu_pkg::TAG_W-1:0] in_tag,
    output logic                      in_ready,

    // Result stream
    output logic                      out_valid,
    output logic [alu_pkg::XLEN-1:0]  out_value,
    output logic                      out_zero,
    output logic [alu_pkg::TAG_W-1:0] out_tag,
    input  logic                      out_ready
);

    // Slice widths follow the package structs
    localparam int CMD_W = $bits(alu_pkg::alu_cmd_t);
    localparam int CTL_W = $bits(alu_pkg::alu_ctl_t);
    localparam int RES_W = $bits(alu_pkg::alu_res_t);

    alu_pkg::alu_cmd_t cmd_in;
    alu_pkg::alu_cmd_t cmd_q;
    alu_pkg::alu_ctl_t ctl_d;
    alu_pkg::alu_ctl_t ctl_q;
    alu_pkg::alu_res_t res_d;
    alu_pkg::alu_res_t res_q;

    logic cmd_valid;
    logic cmd_ready;
    logic dec_valid;
    logic dec_ready;
    logic ctl_valid;
    logic ctl_ready;
    logic exe_valid;
    logic exe_ready;

    assign cmd_in = '{op: in_op, a: in_a, b: in_b, tag: in_tag};

    ////////////////////////////////////////////////////////////////////////////
    // Entry slice and decode
    ////////////////////////////////////////////////////////////////////////////
    register_slice #(.DW(CMD_W)) slice_cmd (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (cmd_in),
        .in_ready  (in_ready),
        .out_valid (cmd_valid),
        .out_data  (cmd_q),
        .out_ready (cmd_ready)
    );

    alu_decode i_alu_decode (
        .in_valid  (cmd_valid),
        .in_cmd    (cmd_q),
        .in_ready  (cmd_ready),
        .out_valid (dec_valid),
        .out_ctl   (ctl_d),
        .out_ready (dec_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Middle slice and execute
    ////////////////////////////////////////////////////////////////////////////
    register_slice #(.DW(CTL_W)) slice_ctl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (dec_valid),
        .in_data   (ctl_d),
        .in_ready  (dec_ready),
        .out_valid (ctl_valid),
        .out_data  (ctl_q),
        .out_ready (ctl_ready)
    );

    alu_execute i_alu_execute (
        .in_valid  (ctl_valid),
        .in_ctl    (ctl_q),
        .in_ready  (ctl_ready),
        .out_valid (exe_valid),
        .out_res   (res_d),
        .out_ready (exe_ready)
    );

    // Exit slice drives the result ports
    register_slice #(.DW(RES_W)) slice_res (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (exe_valid),
        .in_data   (res_d),
        .in_ready  (exe_ready),
        .out_valid (out_valid),
        .out_data  (res_q),
        .out_ready (out_ready)
    );

    assign out_value = res_q.value;
    assign out_zero  = res_q.zero;
    assign out_tag   = res_q.tag;

endmodule

/* tb/tb_clock.sv */
////////////////////////////////////////////////////////////////////////////
// Free running testbench clock, 4 ns period, starts low
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // Toggle every half period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

/* tb/alu_stream_properties.sv */
////////////////////////////////////////////////////////////////////////////
// Handshake assertions on the ALU stream top level ports
// In-flight counter assumes at most 15 items inside the pipeline
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_stream_properties (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      in_valid,
    input logic                      in_ready,
    input logic                      out_valid,
    input logic [alu_pkg::XLEN-1:0]  out_value,
    input logic                      out_zero,
    input logic [alu_pkg::TAG_W-1:0] out_tag,
    input logic                      out_ready
);

    // Commands accepted but not yet delivered
    logic [3:0] in_flight;

    // Count of assertion failures read by the testbench at the end of the run
    int fail_count = 0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + {3'b000, in_valid && in_ready}
                                   - {3'b000, out_valid && out_ready};
        end
    end

    // Stalled result stays put
    stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=>
        (out_valid && $stable(out_value) && $stable(out_zero) && $stable(out_tag)))
        else begin
            $error("Result changed while out_ready was low");
            fail_count++;
        end

    // First cycle out of reset
    reset_exit: assert property (@(posedge clk)
        $rose(rst_n) |-> (in_ready && !out_valid))
        else begin
            $error("Pipeline not idle right after reset");
            fail_count++;
        end

    // No result without a command inside
    no_phantom: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (in_flight != 4'd0))
        else begin
            $error("Result valid with no command in flight");
            fail_count++;
        end

endmodule

bind alu_stream_top alu_stream_properties i_alu_stream_properties (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_value (out_value),
    .out_zero  (out_zero),
    .out_tag   (out_tag),
    .out_ready (out_ready)
);

/* tb/tb_alu_stream.sv */
////////////////////////////////////////////////////////////////////////////
// Trace driven testbench for the ALU stream pipeline
// Runs from the project root and reads at most 64 commands
// Phase 1 runs at full speed while phases 2 and 3 add random gaps and stalls
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_alu_stream;

    localparam int MAX_LINES  = 64;
    localparam int FAST_LINES = 10;

    logic                      clk;
    logic                      rst_n;
    logic                      in_valid;
    alu_pkg::alu_op_e          in_op;
    logic [alu_pkg::XLEN-1:0]  in_a;
    logic [alu_pkg::XLEN-1:0]  in_b;
    logic [alu_pkg::TAG_W-1:0] in_tag;
    logic                      in_ready;
    logic                      out_valid;
    logic [alu_pkg::XLEN-1:0]  out_value;
    logic                      out_zero;
    logic [alu_pkg::TAG_W-1:0] out_tag;
    logic                      out_ready;

    // Trace contents
    logic [2:0]                trace_op  [MAX_LINES];
    logic [alu_pkg::XLEN-1:0]  trace_a   [MAX_LINES];
    logic [alu_pkg::XLEN-1:0]  trace_b   [MAX_LINES];
    logic [alu_pkg::TAG_W-1:0] trace_tag [MAX_LINES];
    logic [alu_pkg::XLEN-1:0]  trace_exp [MAX_LINES];
    int                        n_lines;

    // Trace index and accept cycle of each command in flight
    int pending_idx[$];
    int accept_cyc[$];

    int          errors;
    int          cycle;
    int          cycle_limit;
    int          sent;
    int          received;
    int          last_out_cyc;
    int          fast_lines;
    logic        holding;
    logic        random_on;
    logic [31:0] lfsr;

    tb_clock i_tb_clock (.clk(clk));

    alu_stream_top i_alu_stream_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_tag    (in_tag),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_value (out_value),
        .out_zero  (out_zero),
        .out_tag   (out_tag),
        .out_ready (out_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    task automatic draw_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_advance(lfsr);
    endtask

    function automatic string op_name(input logic [2:0] op);
        string s;
        case (op)
            3'd0:    s = "add";
            3'd1:    s = "sub";
            3'd2:    s = "and";
            3'd3:    s = "or";
            3'd4:    s = "xor";
            3'd5:    s = "sll";
            3'd6:    s = "srl";
            default: s = "slt";
        endcase
        return s;
    endfunction

    // Comment and blank lines fail the scan and are skipped
    task automatic read_trace();
        int          fd;
        int          count;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_tag;
        logic [31:0] f_exp;
        fd = $fopen("tb/alu_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file tb/alu_trace.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                count = $fgets(line, fd);
                if (count > 0) begin
                    count = $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_tag, f_exp);
                    if (count == 5) begin
                        trace_op[n_lines]  = f_op[2:0];
                        trace_a[n_lines]   = f_a;
                        trace_b[n_lines]   = f_b;
                        trace_tag[n_lines] = f_tag[alu_pkg::TAG_W-1:0];
                        trace_exp[n_lines] = f_exp;
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
            if (n_lines == 0) begin
                $display("The trace file holds no commands");
                errors++;
            end
        end
    endtask

    // Idle pipeline state during and right after reset
    task automatic check_idle(input string name);
        if (out_valid !== 1'b0) begin
            $display("Fail %s out_valid expected 0 actual %b", name, out_valid);
            errors++;
        end
        if (in_ready !== 1'b1) begin
            $display("Fail %s in_ready expected 1 actual %b", name, in_ready);
            errors++;
        end
        if (out_value !== '0) begin
            $display("Fail %s out_value expected %h actual %h", name, 32'h0, out_value);
            errors++;
        end
    endtask

    // Compare one delivered result with the oldest command in flight
    task automatic check_result();
        int                       idx;
        int                       issued;
        string                    name;
        logic [alu_pkg::XLEN-1:0] exp_value;
        logic                     exp_zero;
        if (pending_idx.size() == 0) begin
            $display("Result with tag %h arrived with no command outstanding", out_tag);
            errors++;
        end else begin
            idx       = pending_idx.pop_front();
            issued    = accept_cyc.pop_front();
            name      = $sformatf("%s_%0d", op_name(trace_op[idx]), idx);
            exp_value = trace_exp[idx];
            exp_zero  = (exp_value == '0);
            if (out_value !== exp_value) begin
                $display("Fail %s value expected %h actual %h", name, exp_value, out_value);
                errors++;
            end
            if (out_zero !== exp_zero) begin
                $display("Fail %s zero expected %b actual %b", name, exp_zero, out_zero);
                errors++;
            end
            if (out_tag !== trace_tag[idx]) begin
                $display("Fail %s tag expected %h actual %h", name, trace_tag[idx], out_tag);
                errors++;
            end
            // Fixed timing only holds at full speed
            if (!random_on && received == 0 && cycle - issued != 3) begin
                $display("Fail %s latency expected %0d actual %0d", name, 3, cycle - issued);
                errors++;
            end
            if (!random_on && received > 0 && cycle - last_out_cyc != 1) begin
                $display("Fail %s spacing expected %0d actual %0d", name, 1,
                         cycle - last_out_cyc);
                errors++;
            end
        end
        received++;
        last_out_cyc = cycle;
    endtask

    // One clock with inputs driven on the falling edge and handshakes sampled before the rise
    task automatic run_cycle(input int send_limit);
        logic gap;
        logic stall;
        @(negedge clk);
        gap   = 1'b0;
        stall = 1'b0;
        if (random_on) begin
            draw_bit(gap);
            draw_bit(stall);
        end
        out_ready = !stall;
        // A command already offered stays until taken
        if (!holding) begin
            if (sent < send_limit && !gap) begin
                in_valid = 1'b1;
                in_op    = alu_pkg::alu_op_e'(trace_op[sent]);
                in_a     = trace_a[sent];
                in_b     = trace_b[sent];
                in_tag   = trace_tag[sent];
            end else begin
                in_valid = 1'b0;
            end
        end
        #1;
        if (in_valid && in_ready) begin
            pending_idx.push_back(sent);
            accept_cyc.push_back(cycle);
            sent++;
            holding = 1'b0;
        end else begin
            holding = in_valid;
        end
        if (out_valid && out_ready) begin
            check_result();
        end
        cycle++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (cycle_limit > 0 && cycle > cycle_limit) begin
            $display("Run timed out after %0d cycles with %0d of %0d results received",
                     cycle, received, n_lines);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        errors       = 0;
        cycle        = 0;
        cycle_limit  = 0;
        sent         = 0;
        received     = 0;
        last_out_cyc = 0;
        n_lines      = 0;
        holding      = 1'b0;
        random_on    = 1'b0;
        lfsr         = 32'hc26353fc;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_op        = alu_pkg::OP_ADD;
        in_a         = '0;
        in_b         = '0;
        in_tag       = '0;
        out_ready    = 1'b1;

        read_trace();
        cycle_limit = 20 * n_lines + 100;
        fast_lines  = (n_lines < FAST_LINES) ? n_lines : FAST_LINES;

        // Reset held for 8 cycles
        repeat (8) begin
            @(negedge clk);
            check_idle("reset");
        end
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_idle("after_reset");

        // Phase 1 sends back to back with out_ready high
        while (received < fast_lines) begin
            run_cycle(fast_lines);
        end

        // Phase 2 sends the rest of the trace with gaps and stalls
        random_on = 1'b1;
        while (sent < n_lines) begin
            run_cycle(n_lines);
        end

        // Phase 3 drains under stalls and then watches for extra results
        while (received < n_lines) begin
            run_cycle(n_lines);
        end
        repeat (8) begin
            run_cycle(n_lines);
        end

        if (received != n_lines) begin
            $display("Received %0d results for %0d commands", received, n_lines);
            errors++;
        end

        // Bound handshake assertions count toward the error total
        if (i_alu_stream_top.i_alu_stream_properties.fail_count != 0) begin
            $display("Handshake assertions failed %0d times",
                     i_alu_stream_top.i_alu_stream_properties.fail_count);
            errors += i_alu_stream_top.i_alu_stream_properties.fail_count;
        end

        $display("Errors %0d, commands %0d, results %0d, cycles %0d",
                 errors, n_lines, received, cycle);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
logic/alu_pkg.sv
logic/register_slice.sv
logic/alu_decode.sv
logic/alu_execute.sv
logic/alu_stream_top.sv
tb/tb_clock.sv
tb/alu_stream_properties.sv
tb/tb_alu_stream.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_alu_stream
FILELIST := project.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

check:
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/alu_trace.txt */
// Columns: opcode a b tag expected, all hex
// Opcodes: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 srl, 7 slt
0 00000005 00000003 0 00000008
0 ffffffff 00000001 1 00000000
0 7fffffff 00000001 2 80000000
0 12345678 87654321 3 99999999
1 00000005 00000005 4 00000000
1 00000000 00000001 5 ffffffff
1 80000000 00000001 6 7fffffff
1 deadbeef 0000beef 7 dead0000
2 ff00ff00 0f0f0f0f 8 0f000f00
2 aaaaaaaa 55555555 9 00000000
3 ff00ff00 0f0f0f0f a ff0fff0f
3 00000000 00000000 b 00000000
4 ff00ff00 0f0f0f0f c f00ff00f
4 a5a5a5a5 a5a5a5a5 d 00000000
5 00000001 0000001f e 80000000
5 00000001 00000020 f 00000001
5 12345678 00000004 0 23456780
5 80000001 00000021 1 00000002
6 80000000 0000001f 2 00000001
6 12345678 00000004 3 01234567
6 ffffffff 00000024 4 0fffffff
6 00000001 00000001 5 00000000
7 ffffffff 00000001 6 00000001
7 00000001 ffffffff 7 00000000
7 80000000 7fffffff 8 00000001
7 7fffffff 80000000 9 00000000
7 00000005 00000005 a 00000000
7 80000000 80000001 b 00000001
0 80000000 80000000 c 00000000
1 00000003 00000005 d fffffffe
2 12345678 ffffffff e 12345678
3 12340000 00005678 f 12345678
